/* flist.f */
+incdir+source
source/rv_isa_pkg.sv
source/mem_bus_pkg.sv
source/spsram_model.sv
source/mem_arbiter.sv
source/rv_fetch.sv
source/rv_exec.sv
source/rv_soc_top.sv
tests/rv_soc_chk.sv
tests/tb_rv_soc.sv

/* Bender.yml */
package:
  name: rv_soc

sources:
  - include_dirs:
      - source
    files:
      - source/rv_isa_pkg.sv
      - source/mem_bus_pkg.sv
      - source/spsram_model.sv
      - source/mem_arbiter.sv
      - source/rv_fetch.sv
      - source/rv_exec.sv
      - source/rv_soc_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/rv_soc_chk.sv
      - tests/tb_rv_soc.sv

/* tests/tb_rv_soc.sv */
// ------------------------------
// testbench for rv_soc_top, boots small programs and checks every retire
// against an instruction-set reference model
// ------------------------------

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module tb_rv_soc import rv_isa_pkg::*; ();

  logic                  clk;
  logic                  rst_n;
  logic                  run;
  logic                  boot_req;
  logic [`RV_ADDR_W-1:0] boot_addr;
  logic [31:0]           boot_data;
  logic                  boot_ack;
  logic                  retire;
  reg_idx_t              retire_rd;
  logic [31:0]           retire_data;

  integer      seed = 32'hf4cf7522;
  int          cycles;
  int          budget;
  int          checked;
  logic [36:0] exp_q[$];
  instr_t      prog_q[$];
  logic [31:0] ref_rf [32];
  logic [31:0] ref_mem [`RV_MEM_WORDS];
  logic [31:0] ref_pc;
  logic [31:0] halt_pc;
  // last value the DUT retired into each register
  logic [31:0] last_wb [32];

  rv_soc_top u_rv_soc_top (.*);

  always #10 clk = ~clk;

  // ------------------------------
  // instruction encoders
  // ------------------------------
  function automatic instr_t enc_i(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                   logic [11:0] imm, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t enc_add(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {7'b0, rs2, rs1, F3_ADD, rd, OP};
  endfunction

  function automatic instr_t enc_s(logic [2:0] f3, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
  endfunction

  function automatic instr_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, int off);
    logic [12:0] o;
    o = off;
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], BRANCH};
  endfunction

  function automatic instr_t enc_j(reg_idx_t rd, int off);
    logic [20:0] o;
    o = off;
    return {o[20], o[10:1], o[11], o[19:12], rd, JAL};
  endfunction

  // ------------------------------
  // reference model, one instruction per call, returns {rd, data}
  // ------------------------------
  function automatic logic [36:0] ref_step();
    instr_t      w;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a, b, imm_i, imm_s, imm_b, imm_j, res, addr, next;
    logic        wb;
    w     = ref_mem[ref_pc[`RV_ADDR_W+1:2]];
    rd    = w[11:7];
    f3    = w[14:12];
    a     = ref_rf[w[19:15]];
    b     = ref_rf[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    res   = 32'd0;
    wb    = 1'b0;
    next  = ref_pc + 32'd4;
    case (w[6:0])
      7'h33: begin
        res = a + b;
        wb  = 1'b1;
      end
      7'h13: begin
        wb = 1'b1;
        case (f3)
          3'd7:    res = a & imm_i;
          3'd1:    res = a << imm_i[4:0];
          3'd5:    res = a >> imm_i[4:0];
          default: res = a + imm_i;
        endcase
      end
      7'h63: begin
        if ((f3 == 3'd1) ? (a != b) : (a == b)) next = ref_pc + imm_b;
      end
      7'h6f: begin
        res  = ref_pc + 32'd4;
        wb   = 1'b1;
        next = ref_pc + imm_j;
      end
      7'h03: begin
        addr = a + imm_i;
        res  = ref_mem[addr[`RV_ADDR_W+1:2]];
        wb   = 1'b1;
      end
      default: begin
        addr = a + imm_s;
        if (f3 == 3'd2) ref_mem[addr[`RV_ADDR_W+1:2]] = b;
        else ref_mem[addr[`RV_ADDR_W+1:2]][8*addr[1:0] +: 8] = b[7:0];
      end
    endcase
    if (wb && rd != 5'd0) ref_rf[rd] = res;
    ref_pc = next;
    return {wb ? rd : 5'd0, res};
  endfunction

  // ------------------------------
  // compare process and watchdog
  // ------------------------------
  always @(posedge clk) begin
    if (rst_n && retire && exp_q.size() > 0) begin
      logic [36:0] exp;
      exp = exp_q.pop_front();
      assert ({retire_rd, retire_data} == exp) else begin
        $display("FAILED at %0t: retire rd %0d data %h, expected rd %0d data %h",
                 $time, retire_rd, retire_data, exp[36:32], exp[31:0]);
        $display("Test failed");
        $fatal(1);
      end
      if (retire_rd != '0) last_wb[retire_rd] = retire_data;
      checked++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > budget) begin
      $display("timeout, the program did not retire all instructions in time");
      $display("Test failed");
      $fatal(1);
    end
  end

  // ------------------------------
  // stimulus tasks
  // ------------------------------
  // reset held for 8 cycles, outputs watched two cycles beyond
  task automatic reset_dut();
    @(posedge clk);
    rst_n <= 1'b0;
    run   <= 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      assert (!retire && !boot_ack) else begin
        $display("retire or boot_ack was high during or right after reset");
        $display("Test failed");
        $fatal(1);
      end
      if (i == 7) rst_n <= 1'b1;
    end
  endtask

  task automatic boot_word(int idx, logic [31:0] word);
    @(posedge clk);
    boot_req  <= 1'b1;
    boot_addr <= idx;
    boot_data <= word;
    do @(posedge clk); while (!boot_ack);
    boot_req <= 1'b0;
  endtask

  task automatic emit(instr_t w);
    prog_q.push_back(w);
  endtask

  task automatic emit_halt();
    halt_pc = 4 * prog_q.size();
    emit(enc_j(5'd0, 0));
  endtask

  // reset, boot, predict and start the program; gating drops run mid-way
  task automatic run_prog(int gate_len);
    int n;
    int mid;
    int late;
    reset_dut();
    for (int i = 0; i < 32; i++) ref_rf[i] = 32'd0;
    foreach (prog_q[i]) ref_mem[i] = prog_q[i];
    ref_pc = `RV_RESET_PC;
    while (ref_pc != halt_pc && exp_q.size() < 2000) exp_q.push_back(ref_step());
    n       = exp_q.size();
    checked = 0;
    budget  = cycles + 40 * n + 6 * prog_q.size() + gate_len + 40;
    foreach (prog_q[i]) boot_word(i, prog_q[i]);
    @(posedge clk);
    run <= 1'b1;
    if (gate_len > 0) begin
      mid = n / 2;
      while (checked < mid) @(posedge clk);
      run <= 1'b0;
      repeat (4) @(posedge clk);
      late = checked;
      repeat (gate_len) @(posedge clk);
      assert (checked == late) else begin
        $display("an instruction retired while run was low");
        $display("Test failed");
        $fatal(1);
      end
      run <= 1'b1;
    end
    while (checked < n) @(posedge clk);
    prog_q.delete();
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  initial begin
    int          n;
    logic [7:0]  a, b;
    logic [31:0] word;
    logic [31:0] mem_exp;
    clk       = 1'b0;
    rst_n     = 1'b0;
    run       = 1'b0;
    boot_req  = 1'b0;
    boot_addr = '0;
    boot_data = '0;
    cycles    = 0;
    budget    = 200;

    // doubler
    n = 1 + {$random(seed)} % 20;
    emit(enc_i(F3_ADD, 5'd1, 5'd0, 12'd1, OP_IMM));
    for (int i = 0; i < n; i++) emit(enc_add(5'd1, 5'd1, 5'd1));
    emit_halt();
    run_prog(0);
    assert (last_wb[1] == (32'd1 << n)) else begin
      $display("FAILED at %0t: doubler result %h, expected %h",
               $time, last_wb[1], 32'd1 << n);
      $display("Test failed");
      $fatal(1);
    end

    // fibonacci, plain and with run gating
    for (int g = 0; g < 2; g++) begin
      n = 2 + {$random(seed)} % 10;
      emit(enc_i(F3_ADD, 5'd1, 5'd0, 12'd0, OP_IMM));
      emit(enc_i(F3_ADD, 5'd2, 5'd0, 12'd1, OP_IMM));
      for (int i = 0; i < n; i++) begin
        emit(enc_add(5'd3, 5'd1, 5'd2));
        emit(enc_add(5'd1, 5'd2, 5'd0));
        emit(enc_add(5'd2, 5'd3, 5'd0));
      end
      emit_halt();
      run_prog(g ? 5 + {$random(seed)} % 30 : 0);
    end

    // shift-and-add multiply
    a = $random(seed);
    b = $random(seed);
    emit(enc_i(F3_ADD, 5'd1, 5'd0, {4'd0, a}, OP_IMM));
    emit(enc_i(F3_ADD, 5'd2, 5'd0, {4'd0, b}, OP_IMM));
    emit(enc_i(F3_ADD, 5'd3, 5'd0, 12'd0, OP_IMM));
    emit(enc_b(F3_BEQ, 5'd2, 5'd0, 28));
    emit(enc_i(F3_AND, 5'd4, 5'd2, 12'd1, OP_IMM));
    emit(enc_b(F3_BEQ, 5'd4, 5'd0, 8));
    emit(enc_add(5'd3, 5'd3, 5'd1));
    emit(enc_i(F3_SLL, 5'd1, 5'd1, 12'd1, OP_IMM));
    emit(enc_i(F3_SRL, 5'd2, 5'd2, 12'd1, OP_IMM));
    emit(enc_b(F3_BNE, 5'd2, 5'd0, -20));
    emit_halt();
    run_prog(0);
    assert (last_wb[3] == a * b) else begin
      $display("FAILED at %0t: product %0d, expected %0d", $time, last_wb[3], a * b);
      $display("Test failed");
      $fatal(1);
    end

    // memory round trip at byte address 0x100
    word = $random(seed);
    emit(enc_i(F3_ADD, 5'd5, 5'd0, 12'h100, OP_IMM));
    emit(enc_i(F3_ADD, 5'd6, 5'd0, {4'd0, word[31:24]}, OP_IMM));
    for (int k = 2; k >= 0; k--) begin
      emit(enc_i(F3_SLL, 5'd6, 5'd6, 12'd8, OP_IMM));
      emit(enc_i(F3_ADD, 5'd6, 5'd6, {4'd0, word[8*k +: 8]}, OP_IMM));
    end
    emit(enc_s(F3_W, 5'd6, 5'd5, 12'd0));
    mem_exp = word;
    for (int k = 0; k < 4; k++) begin
      a = $random(seed);
      mem_exp[8*k +: 8] = a;
      emit(enc_i(F3_ADD, 5'd7, 5'd0, {4'd0, a}, OP_IMM));
      emit(enc_s(F3_B, 5'd7, 5'd5, k));
    end
    emit(enc_i(F3_W, 5'd8, 5'd5, 12'd0, LOAD));
    emit_halt();
    run_prog(0);
    assert (last_wb[8] == mem_exp) else begin
      $display("FAILED at %0t: loaded word %h, expected %h", $time, last_wb[8], mem_exp);
      $display("Test failed");
      $fatal(1);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* tests/rv_soc_chk.sv */
// ------------------------------
// arbiter protocol assertions, bound into mem_arbiter
// ------------------------------

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_soc_chk (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  run,
  input logic                  instr_req,
  input logic [31:0]           instr_addr,
  input logic                  instr_ack,
  input logic                  data_req,
  input logic [31:0]           data_addr,
  input logic                  data_ack,
  input logic                  boot_req,
  input logic [`RV_ADDR_W-1:0] boot_addr,
  input logic                  boot_ack
);

  // one ack per cycle at most
  a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({boot_ack, data_ack, instr_ack}))
    else $error("more than one ack in the same cycle");

  // each ack answers a request of its own peer
  a_boot_ack: assert property (@(posedge clk) disable iff (!rst_n)
    boot_ack |-> $past(boot_req))
    else $error("boot ack without a boot request");
  a_data_ack: assert property (@(posedge clk) disable iff (!rst_n)
    data_ack |-> $past(data_req))
    else $error("data ack without a data request");
  a_fetch_ack: assert property (@(posedge clk) disable iff (!rst_n)
    instr_ack |-> $past(instr_req) && $past(run))
    else $error("fetch ack without a fetch request while running");

  // address holds while a request waits
  a_fetch_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req && !instr_ack) ##1 instr_req |-> $stable(instr_addr))
    else $error("fetch address changed while waiting for ack");
  a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req && !data_ack) ##1 data_req |-> $stable(data_addr))
    else $error("data address changed while waiting for ack");
  a_boot_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (boot_req && !boot_ack) ##1 boot_req |-> $stable(boot_addr))
    else $error("boot address changed while waiting for ack");

endmodule

bind mem_arbiter rv_soc_chk u_rv_soc_chk (.*);

/* source/rv_soc_top.sv */
// ------------------------------
// rv32 subsystem top, core and boot port sharing one memory
// ------------------------------

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_soc_top import rv_isa_pkg::*; import mem_bus_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  logic                  boot_req,
  input  logic [`RV_ADDR_W-1:0] boot_addr,
  input  logic [31:0]           boot_data,
  output logic                  boot_ack,
  output logic                  retire,
  output reg_idx_t              retire_rd,
  output logic [31:0]           retire_data
);

  logic                  instr_req, instr_ack, instr_valid;
  logic [31:0]           instr_addr;
  instr_t                instr_word;
  logic                  exec_done, redirect;
  logic [31:0]           redirect_pc;
  logic                  data_req, data_ack, data_wr_en;
  logic [31:0]           data_addr, data_wdata;
  byte_mask_t            data_mask;
  logic                  mem_en, mem_wr_en;
  logic [`RV_ADDR_W-1:0] mem_addr;
  logic [31:0]           mem_wdata, mem_rdata;
  byte_mask_t            mem_mask;

  rv_fetch u_rv_fetch (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .instr_req  (instr_req  ),
    .instr_addr (instr_addr ),
    .instr_ack  (instr_ack  ),
    .mem_rdata  (mem_rdata  ),
    .instr_valid(instr_valid),
    .instr_word (instr_word ),
    .exec_done  (exec_done  ),
    .redirect   (redirect   ),
    .redirect_pc(redirect_pc)
  );

  rv_exec u_rv_exec (
    .clk        (clk        ),
    .rst_n      (rst_n      ),
    .instr_valid(instr_valid),
    .instr_word (instr_word ),
    .pc         (instr_addr ),
    .exec_done  (exec_done  ),
    .redirect   (redirect   ),
    .redirect_pc(redirect_pc),
    .data_req   (data_req   ),
    .data_addr  (data_addr  ),
    .data_wdata (data_wdata ),
    .data_mask  (data_mask  ),
    .data_wr_en (data_wr_en ),
    .data_ack   (data_ack   ),
    .mem_rdata  (mem_rdata  ),
    .retire     (retire     ),
    .retire_rd  (retire_rd  ),
    .retire_data(retire_data)
  );

  mem_arbiter u_mem_arbiter (
    .clk       (clk       ),
    .rst_n     (rst_n     ),
    .run       (run       ),
    .instr_req (instr_req ),
    .instr_addr(instr_addr),
    .instr_ack (instr_ack ),
    .data_req  (data_req  ),
    .data_addr (data_addr ),
    .data_wdata(data_wdata),
    .data_mask (data_mask ),
    .data_wr_en(data_wr_en),
    .data_ack  (data_ack  ),
    .boot_req  (boot_req  ),
    .boot_addr (boot_addr ),
    .boot_data (boot_data ),
    .boot_ack  (boot_ack  ),
    .mem_en    (mem_en    ),
    .mem_wr_en (mem_wr_en ),
    .mem_addr  (mem_addr  ),
    .mem_wdata (mem_wdata ),
    .mem_mask  (mem_mask  )
  );

  spsram_model u_spsram (
    .clk  (clk      ),
    .en   (mem_en   ),
    .wr_en(mem_wr_en),
    .addr (mem_addr ),
    .wdata(mem_wdata),
    .mask (mem_mask ),
    .rdata(mem_rdata)
  );

endmodule

/* source/rv_exec.sv */
// ------------------------------
// decode, register file, ALU, branches and load/store for one instruction
// retires every instruction with a one-cycle write-back report
// ------------------------------

`timescale 1ns/1ps

module rv_exec import rv_isa_pkg::*; import mem_bus_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid,
  input  instr_t      instr_word,
  input  logic [31:0] pc,
  output logic        exec_done,
  output logic        redirect,
  output logic [31:0] redirect_pc,
  output logic        data_req,
  output logic [31:0] data_addr,
  output logic [31:0] data_wdata,
  output byte_mask_t  data_mask,
  output logic        data_wr_en,
  input  logic        data_ack,
  input  logic [31:0] mem_rdata,
  output logic        retire,
  output reg_idx_t    retire_rd,
  output logic [31:0] retire_data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ALU,
    ST_MEM
  } state_e;

  state_e      state_q;
  opcode_e     opcode;
  alu_op_e     alu_op;
  logic [2:0]  funct3;
  reg_idx_t    rd, rs1, rs2;
  logic [31:0] rs1_val, rs2_val;
  logic [31:0] imm_i, imm_s, imm_b, imm_j;
  logic [31:0] alu_b, alu_res;
  logic [31:0] wb_data;
  logic        wb_en;
  logic        taken;
  logic        is_mem;

  logic [31:0] rf [32];

  // ------------------------------
  // decode
  // ------------------------------
  assign opcode = opcode_e'(instr_word[6:0]);
  assign rd     = instr_word[11:7];
  assign funct3 = instr_word[14:12];
  assign rs1    = instr_word[19:15];
  assign rs2    = instr_word[24:20];

  assign imm_i = {{20{instr_word[31]}}, instr_word[31:20]};
  assign imm_s = {{20{instr_word[31]}}, instr_word[31:25], instr_word[11:7]};
  assign imm_b = {{19{instr_word[31]}}, instr_word[31], instr_word[7],
                  instr_word[30:25], instr_word[11:8], 1'b0};
  assign imm_j = {{11{instr_word[31]}}, instr_word[31], instr_word[19:12],
                  instr_word[20], instr_word[30:21], 1'b0};

  always_comb begin
    case (funct3)
      F3_AND:  alu_op = AND;
      F3_SLL:  alu_op = SLL;
      F3_SRL:  alu_op = SRL;
      default: alu_op = ADD;
    endcase
  end

  // x0 is hardwired to zero
  assign rs1_val = (rs1 == '0) ? 32'd0 : rf[rs1];
  assign rs2_val = (rs2 == '0) ? 32'd0 : rf[rs2];

  assign is_mem = (opcode == LOAD) || (opcode == STORE);

  // ------------------------------
  // ALU and branch
  // ------------------------------
  assign alu_b = (opcode == OP) ? rs2_val : imm_i;

  always_comb begin
    case (alu_op)
      AND:     alu_res = rs1_val & alu_b;
      SLL:     alu_res = rs1_val << alu_b[4:0];
      SRL:     alu_res = rs1_val >> alu_b[4:0];
      default: alu_res = rs1_val + alu_b;
    endcase
  end

  assign taken = (funct3 == F3_BNE) ? (rs1_val != rs2_val) : (rs1_val == rs2_val);

  assign redirect    = exec_done && ((opcode == JAL) || ((opcode == BRANCH) && taken));
  assign redirect_pc = pc + ((opcode == JAL) ? imm_j : imm_b);

  // ------------------------------
  // load / store
  // ------------------------------
  assign data_req   = (state_q == ST_MEM);
  assign data_wr_en = (opcode == STORE);
  assign data_addr  = rs1_val + ((opcode == STORE) ? imm_s : imm_i);

  always_comb begin
    if (funct3 == F3_W) begin
      data_mask  = MASK_ALL;
      data_wdata = rs2_val;
    end else begin
      // sb, the byte goes on every lane and the mask picks one
      data_mask  = byte_mask_t'(4'b0001 << data_addr[1:0]);
      data_wdata = {4{rs2_val[7:0]}};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (instr_valid) begin
            state_q <= is_mem ? ST_MEM : ST_ALU;
          end
        end
        ST_ALU:  state_q <= ST_IDLE;
        ST_MEM: begin
          if (data_ack) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign exec_done = (state_q == ST_ALU) || ((state_q == ST_MEM) && data_ack);

  // ------------------------------
  // write-back and retire report
  // ------------------------------
  always_comb begin
    wb_en   = 1'b0;
    wb_data = 32'd0;
    case (opcode)
      OP, OP_IMM: begin
        wb_en   = 1'b1;
        wb_data = alu_res;
      end
      JAL: begin
        wb_en   = 1'b1;
        wb_data = pc + 32'd4;
      end
      LOAD: begin
        wb_en   = 1'b1;
        wb_data = mem_rdata;
      end
      default: begin
        wb_en   = 1'b0;
        wb_data = 32'd0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (exec_done && wb_en && (rd != '0)) begin
      rf[rd] <= wb_data;
    end
  end

  assign retire      = exec_done;
  assign retire_rd   = wb_en ? rd : reg_idx_t'(0);
  assign retire_data = wb_data;

endmodule

/* source/rv_fetch.sv */
// ------------------------------
// program counter and single-outstanding instruction fetch
// ------------------------------

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module rv_fetch import rv_isa_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  output logic        instr_req,
  output logic [31:0] instr_addr,
  input  logic        instr_ack,
  input  logic [31:0] mem_rdata,
  output logic        instr_valid,
  output instr_t      instr_word,
  input  logic        exec_done,
  input  logic        redirect,
  input  logic [31:0] redirect_pc
);

  logic [31:0] pc_q;
  logic        req_q;
  logic        valid_q;
  logic        kick_q;
  instr_t      word_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q    <= `RV_RESET_PC;
      req_q   <= 1'b0;
      valid_q <= 1'b0;
      kick_q  <= 1'b1;
    end else begin
      kick_q <= 1'b0;
      // first fetch right after reset, then one per retired instruction
      if (kick_q || exec_done) begin
        req_q <= 1'b1;
      end else if (instr_ack) begin
        req_q <= 1'b0;
      end
      if (instr_ack) begin
        valid_q <= 1'b1;
      end else if (exec_done) begin
        valid_q <= 1'b0;
      end
      if (exec_done) begin
        pc_q <= redirect ? redirect_pc : pc_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_ack) begin
      word_q <= mem_rdata;
    end
  end

  assign instr_req   = req_q;
  assign instr_addr  = pc_q;
  assign instr_valid = valid_q;
  assign instr_word  = word_q;

endmodule

/* source/mem_arbiter.sv */
// ------------------------------
// fixed priority memory arbiter, boot then data then fetch
// ------------------------------

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module mem_arbiter import mem_bus_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  logic                  instr_req,
  input  logic [31:0]           instr_addr,
  output logic                  instr_ack,
  input  logic                  data_req,
  input  logic [31:0]           data_addr,
  input  logic [31:0]           data_wdata,
  input  byte_mask_t            data_mask,
  input  logic                  data_wr_en,
  output logic                  data_ack,
  input  logic                  boot_req,
  input  logic [`RV_ADDR_W-1:0] boot_addr,
  input  logic [31:0]           boot_data,
  output logic                  boot_ack,
  output logic                  mem_en,
  output logic                  mem_wr_en,
  output logic [`RV_ADDR_W-1:0] mem_addr,
  output logic [31:0]           mem_wdata,
  output byte_mask_t            mem_mask
);

  logic       boot_go, data_go, fetch_go;
  requester_e grant;
  requester_e grant_q;
  logic       grant_vld_q;

  // a requester still sees its req high in the ack cycle, so skip it there
  assign boot_go  = boot_req && !boot_ack;
  assign data_go  = data_req && !data_ack && !boot_go;
  assign fetch_go = instr_req && !instr_ack && run && !boot_go && !data_go;

  assign mem_en = boot_go || data_go || fetch_go;

  always_comb begin
    grant     = FETCH;
    mem_wr_en = 1'b0;
    mem_addr  = instr_addr[`RV_ADDR_W+1:2];
    mem_wdata = data_wdata;
    mem_mask  = MASK_ALL;
    if (boot_go) begin
      grant     = BOOT;
      mem_wr_en = 1'b1;
      mem_addr  = boot_addr;
      mem_wdata = boot_data;
    end else if (data_go) begin
      grant     = DATA;
      mem_wr_en = data_wr_en;
      mem_addr  = data_addr[`RV_ADDR_W+1:2];
      mem_mask  = data_mask;
    end
  end

  // winner is remembered for one cycle to route the ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_q     <= BOOT;
      grant_vld_q <= 1'b0;
    end else begin
      grant_q     <= grant;
      grant_vld_q <= mem_en;
    end
  end

  assign boot_ack  = grant_vld_q && (grant_q == BOOT);
  assign data_ack  = grant_vld_q && (grant_q == DATA);
  assign instr_ack = grant_vld_q && (grant_q == FETCH);

endmodule

/* source/spsram_model.sv */
// ------------------------------
// single-port word memory, registered read, byte-masked write
// ------------------------------

`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module spsram_model import mem_bus_pkg::*; (
  input  logic                  clk,
  input  logic                  en,
  input  logic                  wr_en,
  input  logic [`RV_ADDR_W-1:0] addr,
  input  logic [31:0]           wdata,
  input  byte_mask_t            mask,
  output logic [31:0]           rdata
);

  logic [31:0] mem [`RV_MEM_WORDS];

  // read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[addr];
    end
  end

  always_ff @(posedge clk) begin
    if (en && wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          mem[addr][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

/* source/mem_bus_pkg.sv */
// ------------------------------
// types for the shared memory bus and its requesters
// ------------------------------

package mem_bus_pkg;

  // one write enable per byte lane
  typedef logic [3:0] byte_mask_t;

  localparam byte_mask_t MASK_ALL = 4'hF;

  // peers that can own the memory in a cycle
  typedef enum logic [1:0] {
    BOOT  = 2'd0,
    DATA  = 2'd1,
    FETCH = 2'd2
  } requester_e;

endpackage

/* source/rv_isa_pkg.sv */
// ------------------------------
// instruction encodings and decode types for the rv32i subset
// ------------------------------

package rv_isa_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    AND = 2'd1,
    SLL = 2'd2,
    SRL = 2'd3
  } alu_op_e;

  // ------------------------------
  // funct3 fields
  // ------------------------------
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // byte and word width for loads and stores
  localparam logic [2:0] F3_B = 3'b000;
  localparam logic [2:0] F3_W = 3'b010;

endpackage

/* source/rv_core_cfg.svh */
// ------------------------------
// memory size and boot constants for the rv32 subsystem
// include wherever the macros are needed
// ------------------------------

`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// number of 32-bit words in the shared memory
`define RV_MEM_WORDS 1024

// width of the word index into the memory
`define RV_ADDR_W 10

// byte address of the first instruction fetch
`define RV_RESET_PC 32'h0000_0000

`endif
